// ==== source/hazard_pkg.sv ====
package hazard_pkg;

    // ####################
    // basic widths
    // ####################

    typedef logic [4:0]  reg_addr_t;
    typedef logic [63:0] pc_t;
    typedef logic [2:0]  mem_op_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic [31:0] count_t;

    // register x0 is hardwired to zero and never carries a dependency.
    localparam reg_addr_t x0 = 5'd0;

    // memory-operation codes. Only the four loads return their result late.
    localparam mem_op_t mem_none = 3'd0;
    localparam mem_op_t mem_lb   = 3'd1;
    localparam mem_op_t mem_lh   = 3'd2;
    localparam mem_op_t mem_lw   = 3'd4;
    localparam mem_op_t mem_ld   = 3'd6;

    // forwarding selects, ordered from the register file to the oldest stage.
    localparam fwd_sel_t fwd_rf  = 2'd0;
    localparam fwd_sel_t fwd_ex  = 2'd1;
    localparam fwd_sel_t fwd_mem = 2'd2;
    localparam fwd_sel_t fwd_wb  = 2'd3;

    // ####################
    // records
    // ####################

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        mem_op_t   mem_op;
    } decode_info_t;

    typedef struct packed {
        reg_addr_t ex_rd;
        mem_op_t   ex_mem_op;
        reg_addr_t mem_rd;
        reg_addr_t wb_rd;
    } stage_dest_t;

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        fwd_sel_t  fwd1;
        fwd_sel_t  fwd2;
    } issue_info_t;

endpackage

// ==== source/id_hazard_detect.sv ====
module id_hazard_detect (
    input  hazard_pkg::decode_info_t info,
    input  hazard_pkg::stage_dest_t  stages,
    output logic                     ready,
    output hazard_pkg::fwd_sel_t     fwd1,
    output hazard_pkg::fwd_sel_t     fwd2
);

    import hazard_pkg::*;

    logic ex_is_load;
    logic rs1_hit_ex;
    logic rs2_hit_ex;
    logic load_use;

    // picks the youngest stage whose destination matches the source.
    function automatic fwd_sel_t youngest_hit(
        input reg_addr_t   src,
        input stage_dest_t st
    );
        fwd_sel_t sel;
        sel = fwd_rf;
        if (src != x0) begin
            if (src == st.ex_rd) begin
                sel = fwd_ex;
            end else if (src == st.mem_rd) begin
                sel = fwd_mem;
            end else if (src == st.wb_rd) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    // ####################
    // load detection
    // ####################

    // stores and reserved codes fall into the default arm.
    always_comb begin
        case (stages.ex_mem_op)
            mem_lb,
            mem_lh,
            mem_lw,
            mem_ld: begin
                ex_is_load = 1'b1;
            end
            default: begin
                ex_is_load = 1'b0;
            end
        endcase
    end

    // ####################
    // hazard and select
    // ####################

    always_comb begin
        rs1_hit_ex = (info.rs1 != x0) && (info.rs1 == stages.ex_rd);
        rs2_hit_ex = (info.rs2 != x0) && (info.rs2 == stages.ex_rd);
    end

    // a load in EX has no result yet, so decode waits one cycle
    // and then picks the data up from MEM.
    assign load_use = ex_is_load && (rs1_hit_ex || rs2_hit_ex);
    assign ready    = !load_use;

    always_comb begin
        fwd1 = youngest_hit(info.rs1, stages);
        fwd2 = youngest_hit(info.rs2, stages);
    end

endmodule

// ==== source/stage_tracker.sv ====
module stage_tracker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     accept,
    input  hazard_pkg::decode_info_t info,
    input  hazard_pkg::fwd_sel_t     fwd1,
    input  hazard_pkg::fwd_sel_t     fwd2,
    output hazard_pkg::stage_dest_t  stages,
    output logic                     issue_valid,
    output hazard_pkg::issue_info_t  issue_info
);

    import hazard_pkg::*;

    stage_dest_t stage_q;
    reg_addr_t   ex_rd_next;
    mem_op_t     ex_mem_op_next;
    logic        issue_valid_q;
    issue_info_t issue_info_q;

    // ####################
    // EX entry
    // ####################

    // without an accepted instruction a bubble enters EX.
    always_comb begin
        ex_rd_next     = x0;
        ex_mem_op_next = mem_none;
        if (accept) begin
            ex_rd_next     = info.rd;
            ex_mem_op_next = info.mem_op;
        end
    end

    // ####################
    // stage registers
    // ####################

    // the three stages advance on every edge, the pipeline never holds.
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q.ex_rd     <= x0;
            stage_q.ex_mem_op <= mem_none;
            stage_q.mem_rd    <= x0;
            stage_q.wb_rd     <= x0;
        end else begin
            stage_q.wb_rd     <= stage_q.mem_rd;
            stage_q.mem_rd    <= stage_q.ex_rd;
            stage_q.ex_rd     <= ex_rd_next;
            stage_q.ex_mem_op <= ex_mem_op_next;
        end
    end

    assign stages = stage_q;

    // ####################
    // issue record
    // ####################

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= accept;
        end
    end

    // the record stays put between acceptances.
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_info_q.pc   <= info.pc;
            issue_info_q.rd   <= info.rd;
            issue_info_q.fwd1 <= fwd1;
            issue_info_q.fwd2 <= fwd2;
        end
    end

    assign issue_valid = issue_valid_q;
    assign issue_info  = issue_info_q;

endmodule

// ==== source/perf_counters.sv ====
module perf_counters #(
    parameter int count_width = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic                   in_ready,
    output logic [count_width-1:0] issue_count,
    output logic [count_width-1:0] stall_count
);

    logic issue_event;
    logic stall_event;

    logic [count_width-1:0] issue_q;
    logic [count_width-1:0] stall_q;

    assign issue_event = in_valid && in_ready;
    assign stall_event = in_valid && !in_ready;

    // ####################
    // counters
    // ####################

    // both counters simply roll over at the top of their range.
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q <= '0;
            stall_q <= '0;
        end else begin
            if (issue_event) begin
                issue_q <= issue_q + 1'b1;
            end
            if (stall_event) begin
                stall_q <= stall_q + 1'b1;
            end
        end
    end

    assign issue_count = issue_q;
    assign stall_count = stall_q;

endmodule

// ==== source/hazard_unit_top.sv ====
module hazard_unit_top #(
    parameter int count_width = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  hazard_pkg::decode_info_t in_info,
    output logic                     in_ready,
    output logic                     issue_valid,
    output hazard_pkg::issue_info_t  issue_info,
    output logic [count_width-1:0]   issue_count,
    output logic [count_width-1:0]   stall_count
);

    import hazard_pkg::*;

    stage_dest_t stages;
    fwd_sel_t    fwd1;
    fwd_sel_t    fwd2;
    logic        accept;

    // an instruction leaves decode only when the detector lets it go.
    assign accept = in_valid && in_ready;

    // ####################
    // blocks
    // ####################

    id_hazard_detect u_detect (
        .info   (in_info),
        .stages (stages),
        .ready  (in_ready),
        .fwd1   (fwd1),
        .fwd2   (fwd2)
    );

    stage_tracker u_tracker (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .info        (in_info),
        .fwd1        (fwd1),
        .fwd2        (fwd2),
        .stages      (stages),
        .issue_valid (issue_valid),
        .issue_info  (issue_info)
    );

    perf_counters #(
        .count_width (count_width)
    ) u_counters (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .issue_count (issue_count),
        .stall_count (stall_count)
    );

endmodule

// ==== sim/hazard_unit_checker.sv ====
module hazard_unit_checker #(
    parameter int count_width = 32
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     in_valid,
    input hazard_pkg::decode_info_t in_info,
    input logic                     in_ready,
    input logic                     issue_valid,
    input logic [count_width-1:0]   issue_count,
    input logic [count_width-1:0]   stall_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // ####################
    // protocol properties
    // ####################

    // the issue register clears while reset is high.
    assert property (@(posedge clk) $past(reset) |-> !issue_valid)
        else $error("issue_valid is high in the cycle after reset");

    // an issue record always belongs to an acceptance one cycle earlier.
    assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> $past(in_valid && in_ready))
        else $error("issue_valid is high without an acceptance in the previous cycle");

    // a load-use stall clears after one cycle, as the load then sits in MEM.
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && $past(in_valid && !in_ready) && (in_info == $past(in_info))) |-> in_ready)
        else $error("in_ready stayed low for two cycles on the same instruction");

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (issue_count >= $past(issue_count))
                          && (stall_count >= $past(stall_count)))
        else $error("a performance counter decreased outside reset");

endmodule

bind hazard_unit_top hazard_unit_checker #(
    .count_width (count_width)
) u_checker (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_info     (in_info),
    .in_ready    (in_ready),
    .issue_valid (issue_valid),
    .issue_count (issue_count),
    .stall_count (stall_count)
);

// ==== sim/hazard_unit_tb.sv ====
module hazard_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import hazard_pkg::*;

    typedef struct packed {
        logic [3:0]   gap;
        decode_info_t info;
    } entry_t;

    logic         clk;
    logic         reset;
    logic         in_valid;
    decode_info_t in_info;
    logic         in_ready;
    logic         issue_valid;
    issue_info_t  issue_info;
    count_t       issue_count;
    count_t       stall_count;

    entry_t       entries[$];
    // reference copies of the destinations held in EX, MEM and WB.
    reg_addr_t    ref_ex_rd;
    mem_op_t      ref_ex_op;
    reg_addr_t    ref_mem_rd;
    reg_addr_t    ref_wb_rd;
    logic         exp_issue_valid;
    issue_info_t  exp_issue;
    count_t       exp_issue_count;
    count_t       exp_stall_count;
    int           ready_errors;
    int           issue_errors;
    int           count_errors;
    int           cycles;
    int           cycle_limit;

    hazard_unit_top #(
        .count_width (32)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_info     (in_info),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .issue_info  (issue_info),
        .issue_count (issue_count),
        .stall_count (stall_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // ####################
    // reference model
    // ####################

    function automatic logic is_load(input mem_op_t op);
        return (op == 3'd1) || (op == 3'd2) || (op == 3'd4) || (op == 3'd6);
    endfunction

    // the youngest stage holding the source register supplies its value.
    function automatic fwd_sel_t ref_select(input reg_addr_t src);
        fwd_sel_t sel;
        sel = 2'd0;
        if (src == 5'd0) begin
            sel = 2'd0;
        end else if (src == ref_ex_rd) begin
            sel = 2'd1;
        end else if (src == ref_mem_rd) begin
            sel = 2'd2;
        end else if (src == ref_wb_rd) begin
            sel = 2'd3;
        end
        return sel;
    endfunction

    task automatic add_entry(input int gap, input int rs1, input int rs2,
                             input int rd, input int op);
        entry_t e;
        e.gap         = gap[3:0];
        e.info.pc     = 64'h8000_0000 + 64'(entries.size() * 4);
        e.info.rs1    = rs1[4:0];
        e.info.rs2    = rs2[4:0];
        e.info.rd     = rd[4:0];
        e.info.mem_op = op[2:0];
        entries.push_back(e);
    endtask

    // outputs are compared at the falling edge, half a cycle after the drive.
    task automatic check_cycle(output logic accepted);
        logic     exp_ready;
        logic     hit1;
        logic     hit2;
        fwd_sel_t sel1;
        fwd_sel_t sel2;
        @(negedge clk);
        if (issue_valid !== exp_issue_valid) begin
            $display("Error at %0d ns: issue_valid expected %0b, got %0b",
                     $time, exp_issue_valid, issue_valid);
            issue_errors++;
        end else if (issue_valid && (issue_info !== exp_issue)) begin
            $display("Error at %0d ns: issue_info expected %h, got %h",
                     $time, exp_issue, issue_info);
            issue_errors++;
        end
        if (issue_count !== exp_issue_count) begin
            $display("Error at %0d ns: issue_count expected %0d, got %0d",
                     $time, exp_issue_count, issue_count);
            count_errors++;
        end
        if (stall_count !== exp_stall_count) begin
            $display("Error at %0d ns: stall_count expected %0d, got %0d",
                     $time, exp_stall_count, stall_count);
            count_errors++;
        end
        hit1 = (in_info.rs1 != 5'd0) && (in_info.rs1 == ref_ex_rd);
        hit2 = (in_info.rs2 != 5'd0) && (in_info.rs2 == ref_ex_rd);
        exp_ready = !(is_load(ref_ex_op) && (hit1 || hit2));
        sel1 = ref_select(in_info.rs1);
        sel2 = ref_select(in_info.rs2);
        if (in_valid && (in_ready !== exp_ready)) begin
            $display("Error at %0d ns: in_ready expected %0b, got %0b",
                     $time, exp_ready, in_ready);
            ready_errors++;
        end
        accepted = in_valid && exp_ready;
        exp_issue_valid = accepted;
        if (accepted) begin
            exp_issue.pc    = in_info.pc;
            exp_issue.rd    = in_info.rd;
            exp_issue.fwd1  = sel1;
            exp_issue.fwd2  = sel2;
            exp_issue_count = exp_issue_count + 32'd1;
        end
        if (in_valid && !exp_ready) begin
            exp_stall_count = exp_stall_count + 32'd1;
        end
        ref_wb_rd  = ref_mem_rd;
        ref_mem_rd = ref_ex_rd;
        ref_ex_rd  = accepted ? in_info.rd : 5'd0;
        ref_ex_op  = accepted ? in_info.mem_op : 3'd0;
    endtask

    task automatic drive_cycle(input logic valid, input decode_info_t info,
                               output logic accepted);
        @(posedge clk);
        in_valid <= valid;
        in_info  <= info;
        check_cycle(accepted);
    endtask

    // ####################
    // stimulus
    // ####################

    initial begin
        int     gap_sum;
        int     total;
        logic   accepted;
        entry_t e;
        void'($urandom(32'h69afc64d));
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_info = '0;
        cycles = 0;
        ref_ex_rd = 5'd0;
        ref_ex_op = 3'd0;
        ref_mem_rd = 5'd0;
        ref_wb_rd = 5'd0;
        exp_issue_valid = 1'b0;
        exp_issue = '0;
        exp_issue_count = 32'd0;
        exp_stall_count = 32'd0;
        ready_errors = 0;
        issue_errors = 0;
        count_errors = 0;
        // columns are gap, rs1, rs2, rd and mem_op.
        add_entry(2, 0, 0, 5, 0);
        add_entry(0, 5, 0, 6, 0);
        add_entry(0, 5, 6, 7, 0);
        add_entry(0, 5, 6, 8, 0);
        add_entry(0, 5, 0, 9, 0);
        add_entry(0, 0, 0, 10, 0);
        add_entry(0, 0, 0, 10, 0);
        add_entry(0, 10, 10, 11, 0);
        // loads followed at once by a user of the loaded register.
        add_entry(0, 0, 0, 12, 4);
        add_entry(0, 12, 0, 13, 0);
        add_entry(0, 0, 0, 14, 6);
        add_entry(0, 1, 14, 15, 0);
        add_entry(0, 0, 0, 16, 1);
        add_entry(0, 16, 16, 17, 0);
        add_entry(0, 0, 0, 18, 2);
        add_entry(0, 0, 18, 19, 0);
        // x0, stores, reserved codes and an unrelated load.
        add_entry(0, 0, 0, 0, 4);
        add_entry(0, 0, 0, 20, 0);
        add_entry(0, 0, 0, 21, 3);
        add_entry(0, 21, 0, 22, 0);
        add_entry(0, 0, 0, 23, 7);
        add_entry(0, 23, 0, 24, 0);
        add_entry(0, 0, 0, 25, 4);
        add_entry(0, 3, 4, 26, 0);
        // dependencies across idle gaps.
        add_entry(0, 0, 0, 27, 0);
        add_entry(1, 27, 0, 28, 0);
        add_entry(2, 28, 0, 29, 0);
        add_entry(3, 29, 0, 30, 0);
        add_entry(0, 0, 0, 31, 4);
        add_entry(1, 31, 0, 1, 0);
        for (int i = 0; i < 12; i++) begin
            add_entry(int'($urandom % 3), int'($urandom % 32), int'($urandom % 32),
                      int'($urandom % 32), (($urandom % 2) == 1) ? 4 : 0);
        end
        gap_sum = 0;
        foreach (entries[i]) begin
            gap_sum += int'(entries[i].gap);
        end
        cycle_limit = 2 * (entries.size() + gap_sum) + 50;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (entries[i]) begin
            e = entries[i];
            repeat (e.gap) drive_cycle(1'b0, '0, accepted);
            accepted = 1'b0;
            while (!accepted) begin
                drive_cycle(1'b1, e.info, accepted);
            end
        end
        repeat (4) drive_cycle(1'b0, '0, accepted);
        if (issue_count !== 32'(entries.size())) begin
            $display("Error at %0d ns: issue_count expected %0d, got %0d",
                     $time, entries.size(), issue_count);
            count_errors++;
        end
        total = ready_errors + issue_errors + count_errors;
        $display("error counts: ready %0d, issue %0d, counters %0d, total %0d",
                 ready_errors, issue_errors, count_errors, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/hazard_pkg.sv
source/id_hazard_detect.sv
source/stage_tracker.sv
source/perf_counters.sv
source/hazard_unit_top.sv
sim/hazard_unit_checker.sv
sim/hazard_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module hazard_unit_tb -o hazard_unit_sim

status=0
./obj_dir/hazard_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
